/* hdl/zx_pkg.sv */
package zx_pkg;

	//////////////////////////////////////////////////
	// memory pages
	//////////////////////////////////////////////////

	localparam int PAGE_W = 8;

	typedef logic [PAGE_W-1:0] page_t;

	// fixed pages of windows 1 and 2 (4000 and 8000)
	localparam page_t WIN_PAGE1 = 8'd5;
	localparam page_t WIN_PAGE2 = 8'd2;

	//////////////////////////////////////////////////
	// i/o ports
	//////////////////////////////////////////////////

	localparam logic [15:0] PORT_EFF7_ADDR = 16'hEFF7;

	// low byte of the window page readback port
	localparam logic [7:0] PORT_BE_LOW = 8'hBE;

	// high byte of the tr-dos entry point
	localparam logic [7:0] DOS_ENTRY_HI = 8'h3D;

	// nobody answers, bus floats high
	localparam logic [7:0] OPEN_BUS = 8'hFF;

	// five ports need a third bit
	typedef enum logic [2:0] {
		PORT_NONE = 3'd0,
		PORT_7FFD = 3'd1,
		PORT_EFF7 = 3'd2,
		PORT_FE   = 3'd3,
		PORT_BE   = 3'd4
	} port_id_e;

	// rom bank numbers as seen on mem_page
	typedef enum logic [1:0] {
		ROM_BASIC128 = 2'd0,
		ROM_BASIC48  = 2'd1,
		ROM_TRDOS    = 2'd2
	} rom_bank_e;

endpackage

/* hdl/zx_bus_if.sv */
`timescale 1ns/100ps

// decoded z80 bus cycle
interface zx_cycle_if;

	logic                port_wr;
	logic                port_rd;
	zx_pkg::port_id_e    port_id;
	logic [7:0]          port_data;
	logic                m1_fetch;
	logic [15:0]         addr;

	modport decoder (
		output port_wr, port_rd, port_id, port_data, m1_fetch, addr
	);

	modport regs (
		input port_wr, port_id, port_data, m1_fetch, addr
	);

	modport map (
		input port_rd, port_id, addr
	);

endinterface

// paging state from the port registers
interface zx_map_if;

	zx_pkg::rom_bank_e rom_bank;
	logic              ram0_in_rom;
	zx_pkg::page_t     page3;

	modport regs (
		output rom_bank, ram0_in_rom, page3
	);

	modport map (
		input rom_bank, ram0_in_rom, page3
	);

endinterface

/* hdl/zx_bus_decode.sv */
`timescale 1ns/100ps

module zx_bus_decode (
	input  logic        fclk,
	input  logic        reset,
	input  logic [15:0] a,
	input  logic [7:0]  d_in,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic        mreq_n,
	zx_cycle_if.decoder cyc
);

	logic [15:0] a_r;
	logic [7:0]  d_r;
	logic        iorq_r;
	logic        rd_r;
	logic        wr_r;
	logic        m1_r;
	logic        mreq_r;

	logic        wr_act;
	logic        rd_act;
	logic        m1_act;
	logic        wr_act_q;
	logic        m1_act_q;

	zx_pkg::port_id_e id_next;

	//////////////////////////////////////////////////
	// input sampling
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		a_r <= a;
		d_r <= d_in;
		if (reset)
		begin
			iorq_r <= 1'b1;
			rd_r   <= 1'b1;
			wr_r   <= 1'b1;
			m1_r   <= 1'b1;
			mreq_r <= 1'b1;
		end
		else
		begin
			iorq_r <= iorq_n;
			rd_r   <= rd_n;
			wr_r   <= wr_n;
			m1_r   <= m1_n;
			mreq_r <= mreq_n;
		end
	end

	assign wr_act = ~iorq_r & ~wr_r;
	assign rd_act = ~iorq_r & ~rd_r;
	assign m1_act = ~m1_r & ~mreq_r;

	// FE and BE share a[0]=0, so direction picks between them
	always_comb
	begin
		id_next = zx_pkg::PORT_NONE;
		if (rd_act)
		begin
			if (a_r[7:0] == zx_pkg::PORT_BE_LOW)
				id_next = zx_pkg::PORT_BE;
		end
		else if (a_r == zx_pkg::PORT_EFF7_ADDR)
			id_next = zx_pkg::PORT_EFF7;
		else if (!a_r[15] && !a_r[1] && a_r[0])
			id_next = zx_pkg::PORT_7FFD;
		else if (!a_r[0])
			id_next = zx_pkg::PORT_FE;
	end

	//////////////////////////////////////////////////
	// cycle events
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		cyc.addr      <= a_r;
		cyc.port_data <= d_r;
		if (reset)
		begin
			wr_act_q     <= 1'b0;
			m1_act_q     <= 1'b0;
			cyc.port_wr  <= 1'b0;
			cyc.port_rd  <= 1'b0;
			cyc.m1_fetch <= 1'b0;
			cyc.port_id  <= zx_pkg::PORT_NONE;
		end
		else
		begin
			wr_act_q     <= wr_act;
			m1_act_q     <= m1_act;
			// rising edges only, one event per bus cycle
			cyc.port_wr  <= wr_act & ~wr_act_q;
			cyc.m1_fetch <= m1_act & ~m1_act_q;
			cyc.port_rd  <= rd_act;
			cyc.port_id  <= id_next;
		end
	end

endmodule

/* hdl/zx_port_regs.sv */
`timescale 1ns/100ps

module zx_port_regs (
	input  logic       fclk,
	input  logic       reset,
	zx_cycle_if.regs   cyc,
	zx_map_if.regs     map,
	output logic [2:0] border,
	output logic       beep,
	output logic       dos
);

	// kept fields of 7FFD
	logic [1:0] page_hi;
	logic [2:0] page_lo;
	logic       rom_sel;
	logic       lock;

	logic       wr_7ffd;
	logic       wr_eff7;
	logic       wr_fe;

	assign wr_7ffd = cyc.port_wr && (cyc.port_id == zx_pkg::PORT_7FFD) && !lock;
	assign wr_eff7 = cyc.port_wr && (cyc.port_id == zx_pkg::PORT_EFF7);
	assign wr_fe   = cyc.port_wr && (cyc.port_id == zx_pkg::PORT_FE);

	//////////////////////////////////////////////////
	// port registers
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			page_hi         <= 2'd0;
			page_lo         <= 3'd0;
			rom_sel         <= 1'b0;
			lock            <= 1'b0;
			map.ram0_in_rom <= 1'b0;
			border          <= 3'd0;
			beep            <= 1'b0;
		end
		else
		begin
			// lock holds until reset
			if (wr_7ffd)
			begin
				page_hi <= cyc.port_data[7:6];
				lock    <= cyc.port_data[5];
				rom_sel <= cyc.port_data[4];
				page_lo <= cyc.port_data[2:0];
			end
			if (wr_eff7)
				map.ram0_in_rom <= cyc.port_data[3];
			if (wr_fe)
			begin
				border <= cyc.port_data[2:0];
				beep   <= cyc.port_data[4];
			end
		end
	end

	//////////////////////////////////////////////////
	// tr-dos switch
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
			dos <= 1'b0;
		else if (cyc.m1_fetch)
		begin
			if (cyc.addr[15:8] == zx_pkg::DOS_ENTRY_HI && map.rom_bank == zx_pkg::ROM_BASIC48)
				dos <= 1'b1;
			else if (cyc.addr[15:14] != 2'd0)
				dos <= 1'b0;
		end
	end

	assign map.rom_bank = dos     ? zx_pkg::ROM_TRDOS :
	                      rom_sel ? zx_pkg::ROM_BASIC48 : zx_pkg::ROM_BASIC128;

	// pentagon-512 page of window 3
	assign map.page3 = {3'd0, page_hi, page_lo};

endmodule

/* hdl/zx_mem_map.sv */
`timescale 1ns/100ps

module zx_mem_map (
	input  logic          fclk,
	input  logic          reset,
	zx_cycle_if.map       cyc,
	zx_map_if.map         map,
	output logic          mem_rom,
	output zx_pkg::page_t mem_page,
	output logic [7:0]    d_out,
	output logic          d_oe
);

	zx_pkg::page_t pages [0:3];
	logic          win0_rom;
	logic [1:0]    win;
	logic [1:0]    rb_win;
	logic          rb_hit;

	//////////////////////////////////////////////////
	// window pages
	//////////////////////////////////////////////////

	assign win0_rom = ~map.ram0_in_rom;

	// window 0 is either a rom bank or ram page 0
	assign pages[0] = win0_rom ? zx_pkg::page_t'(map.rom_bank) : '0;
	assign pages[1] = zx_pkg::WIN_PAGE1;
	assign pages[2] = zx_pkg::WIN_PAGE2;
	assign pages[3] = map.page3;

	assign win = cyc.addr[15:14];

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			mem_rom  <= 1'b1;
			mem_page <= '0;
		end
		else
		begin
			mem_rom  <= (win == 2'd0) && win0_rom;
			mem_page <= pages[win];
		end
	end

	//////////////////////////////////////////////////
	// read data
	//////////////////////////////////////////////////

	// xxBE with high byte 00..03 reads back that window
	assign rb_win = cyc.addr[9:8];
	assign rb_hit = (cyc.port_id == zx_pkg::PORT_BE) && (cyc.addr[15:10] == 6'd0);

	always_ff @(posedge fclk)
	begin
		d_out <= rb_hit ? pages[rb_win] : zx_pkg::OPEN_BUS;
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
			d_oe <= 1'b0;
		else
			d_oe <= cyc.port_rd;
	end

endmodule

/* hdl/zx_pager_top.sv */
`timescale 1ns/100ps

module zx_pager_top (
	input  logic          fclk,
	input  logic          reset,
	input  logic [15:0]   a,
	input  logic [7:0]    d_in,
	input  logic          iorq_n,
	input  logic          mreq_n,
	input  logic          rd_n,
	input  logic          wr_n,
	input  logic          m1_n,
	output logic [7:0]    d_out,
	output logic          d_oe,
	output logic          mem_rom,
	output zx_pkg::page_t mem_page,
	output logic [2:0]    border,
	output logic          beep,
	output logic          dos
);

	zx_cycle_if cyc ();
	zx_map_if   map ();

	// z80 strobes to cycle events
	zx_bus_decode u_decode (
		.fclk   (fclk),
		.reset  (reset),
		.a      (a),
		.d_in   (d_in),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.mreq_n (mreq_n),
		.cyc    (cyc.decoder)
	);

	zx_port_regs u_regs (
		.fclk   (fclk),
		.reset  (reset),
		.cyc    (cyc.regs),
		.map    (map.regs),
		.border (border),
		.beep   (beep),
		.dos    (dos)
	);

	zx_mem_map u_map (
		.fclk     (fclk),
		.reset    (reset),
		.cyc      (cyc.map),
		.map      (map.map),
		.mem_rom  (mem_rom),
		.mem_page (mem_page),
		.d_out    (d_out),
		.d_oe     (d_oe)
	);

endmodule

/* dv/zx_pager_assertions.sv */
`timescale 1ns/100ps

module zx_pager_assertions (
	input logic          fclk,
	input logic          reset,
	input logic [15:0]   a,
	input logic          iorq_n,
	input logic          rd_n,
	input logic [7:0]    d_out,
	input logic          d_oe,
	input logic          mem_rom,
	input zx_pkg::page_t mem_page,
	input logic [2:0]    border,
	input logic          beep,
	input logic          dos
);

	int fail_count = 0;

	// outputs clean one cycle into reset
	a_reset_state: assert property (
		@(posedge fclk) reset |=> (!d_oe && !beep && !dos && border == 3'd0)
	)
	else
	begin
		fail_count++;
		$error("d_oe, beep, dos or border not cleared by reset");
	end

	// sample, decode and output stages
	a_oe_follows_read: assert property (
		@(posedge fclk) disable iff (reset)
		d_oe == $past(!iorq_n && !rd_n, 3)
	)
	else
	begin
		fail_count++;
		$error("d_oe does not follow the i/o read strobe");
	end

	a_open_bus: assert property (
		@(posedge fclk) disable iff (reset)
		(d_oe && !($past(a[7:0], 3) == zx_pkg::PORT_BE_LOW && $past(a[15:10], 3) == 6'd0))
		|-> d_out == zx_pkg::OPEN_BUS
	)
	else
	begin
		fail_count++;
		$error("unclaimed i/o read did not return open bus");
	end

	// tr-dos rom is bank 2
	a_dos_rom: assert property (
		@(posedge fclk) disable iff (reset)
		(mem_rom && $past(dos)) |-> mem_page == 8'd2
	)
	else
	begin
		fail_count++;
		$error("window 0 does not show the tr-dos rom while dos is set");
	end

endmodule

/* dv/tb_zx_pager.sv */
`timescale 1ns/100ps

module tb_zx_pager;

	localparam int CLK_PERIOD = 8;
	// bus tasks issued by the main sequence
	localparam int N_TASKS = 30;
	localparam int WATCHDOG_NS = (N_TASKS * 12 + 50) * CLK_PERIOD;

	logic          fclk;
	logic          reset;
	logic [15:0]   a;
	logic [7:0]    d_in;
	logic          iorq_n;
	logic          mreq_n;
	logic          rd_n;
	logic          wr_n;
	logic          m1_n;
	logic [7:0]    d_out;
	logic          d_oe;
	logic          mem_rom;
	zx_pkg::page_t mem_page;
	logic [2:0]    border;
	logic          beep;
	logic          dos;

	logic [31:0]   rnd;
	logic [7:0]    v;
	logic [7:0]    lock_v;
	logic          rom;
	logic [7:0]    page;
	logic [7:0]    data;
	logic          oe;

	zx_pager_top UUT (.*);

	bind zx_pager_top zx_pager_assertions u_chk (
		.fclk (fclk), .reset (reset), .a (a), .iorq_n (iorq_n), .rd_n (rd_n),
		.d_out (d_out), .d_oe (d_oe), .mem_rom (mem_rom), .mem_page (mem_page),
		.border (border), .beep (beep), .dos (dos)
	);

	always #(CLK_PERIOD / 2) fclk = ~fclk;

	//////////////////////////////////////////////////
	// z80 bus cycles with strobes held 4 clocks
	//////////////////////////////////////////////////

	task automatic io_write(input logic [15:0] addr, input logic [7:0] value);
		@(posedge fclk);
		a      <= addr;
		d_in   <= value;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		repeat (4) @(posedge fclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [7:0] value, output logic en);
		@(posedge fclk);
		a      <= addr;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		repeat (3) @(posedge fclk);
		@(negedge fclk);
		value = d_out;
		en    = d_oe;
		@(posedge fclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	// m1 low turns the read into an opcode fetch
	task automatic mem_cycle(input logic [15:0] addr, input logic fetch,
	                         output logic is_rom, output logic [7:0] pg);
		@(posedge fclk);
		a      <= addr;
		mreq_n <= 1'b0;
		rd_n   <= 1'b0;
		m1_n   <= ~fetch;
		repeat (3) @(posedge fclk);
		@(negedge fclk);
		is_rom = mem_rom;
		pg     = mem_page;
		@(posedge fclk);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		m1_n   <= 1'b1;
	endtask

	task automatic check_val(input string name, input logic [7:0] expected,
	                         input logic [7:0] actual);
		assert (actual === expected)
		else
		begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		fclk   = 1'b0;
		reset  = 1'b1;
		a      = 16'h0000;
		d_in   = 8'h00;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		void'($urandom(32'h1b17_4652));
		repeat (5) @(posedge fclk);
		reset <= 1'b0;
		repeat (2) @(posedge fclk);
		@(negedge fclk);
		check_val("reset d_oe", 8'd0, {7'd0, d_oe});
		check_val("reset beep", 8'd0, {7'd0, beep});
		check_val("reset dos", 8'd0, {7'd0, dos});
		mem_cycle(16'hC000, 1'b0, rom, page);
		check_val("reset window 3", 8'd0, page);
		mem_cycle(16'h0000, 1'b0, rom, page);
		check_val("reset rom flag", 8'd1, {7'd0, rom});
		check_val("reset rom bank", 8'(zx_pkg::ROM_BASIC128), page);

		// page3 is 7FFD bits 7:6 and 2:0
		repeat (4)
		begin
			rnd = $urandom();
			v   = rnd[7:0] & 8'hDF;
			io_write(16'h7FFD, v);
			mem_cycle(16'hC000, 1'b0, rom, page);
			check_val("7ffd window 3", {3'd0, v[7:6], v[2:0]}, page);
		end
		mem_cycle(16'h4000, 1'b0, rom, page);
		check_val("window 1", 8'd5, page);
		mem_cycle(16'h8000, 1'b0, rom, page);
		check_val("window 2", 8'd2, page);

		// tr-dos entry needs the 48 rom
		io_write(16'h7FFD, 8'h10);
		mem_cycle(16'h3D2F, 1'b1, rom, page);
		check_val("dos set", 8'd1, {7'd0, dos});
		mem_cycle(16'h0000, 1'b0, rom, page);
		check_val("dos rom bank", 8'(zx_pkg::ROM_TRDOS), page);
		mem_cycle(16'h8000, 1'b1, rom, page);
		check_val("dos cleared", 8'd0, {7'd0, dos});
		io_write(16'h7FFD, 8'h00);
		mem_cycle(16'h3D2F, 1'b1, rom, page);
		check_val("dos with 128 rom", 8'd0, {7'd0, dos});

		// 48 rom selected so a missed remap shows bank 1
		io_write(16'h7FFD, 8'h10);
		io_write(16'hEFF7, 8'h08);
		mem_cycle(16'h0000, 1'b0, rom, page);
		check_val("eff7 rom flag", 8'd0, {7'd0, rom});
		check_val("eff7 window 0", 8'd0, page);
		io_write(16'hEFF7, 8'h00);

		rnd = $urandom();
		v   = rnd[7:0];
		io_write(16'h00FE, v);
		repeat (4) @(posedge fclk);
		@(negedge fclk);
		check_val("fe border", {5'd0, v[2:0]}, {5'd0, border});
		check_val("fe beep", {7'd0, v[4]}, {7'd0, beep});

		rnd = $urandom();
		v   = rnd[7:0] & 8'hDF;
		io_write(16'h7FFD, v);
		io_read(16'h03BE, data, oe);
		check_val("readback oe", 8'd1, {7'd0, oe});
		check_val("readback window 3", {3'd0, v[7:6], v[2:0]}, data);
		io_read(16'h7FFD, data, oe);
		check_val("open bus 7ffd", 8'hFF, data);
		io_read(16'h04BE, data, oe);
		check_val("open bus 04be", 8'hFF, data);

		// second write must be ignored once locked
		rnd    = $urandom();
		lock_v = (rnd[7:0] & 8'hC7) | 8'h20;
		io_write(16'h7FFD, lock_v);
		io_write(16'h7FFD, lock_v ^ 8'hC7);
		mem_cycle(16'hC000, 1'b0, rom, page);
		check_val("7ffd lock", {3'd0, lock_v[7:6], lock_v[2:0]}, page);

		repeat (4) @(posedge fclk);
		if (UUT.u_chk.fail_count == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("Checks failed");
			$fatal(1, "bus checker assertions failed");
		end
	end

	always @(negedge fclk)
	begin
		if (UUT.u_chk.fail_count != 0)
		begin
			$display("Checks failed");
			$fatal(1, "a concurrent assertion in the bus checker failed");
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Checks failed");
		$fatal(1, "watchdog expired before the bus sequence finished");
	end

endmodule

/* filelist.f */
hdl/zx_pkg.sv
hdl/zx_bus_if.sv
hdl/zx_bus_decode.sv
hdl/zx_port_regs.sv
hdl/zx_mem_map.sv
hdl/zx_pager_top.sv
dv/zx_pager_assertions.sv
dv/tb_zx_pager.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the zx pager testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_zx_pager \
	-f filelist.f --Mdir obj_dir -o sim_zx_pager
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_zx_pager > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	exit 1
fi
exit 0
